// ==== verilog.f ====
+incdir+.
mycpu_pkg.sv
alu.sv
divider.sv
store_align.sv
data_ram.sv
exe_stage.sv
mem_stage.sv
ram_arbiter.sv
exec_core_top.sv
tb_exec_core.sv

// ==== tb_vectors.svh ====
    // columns are name, op, rs, rt, imm, dest, expected result and expected exc
    task load_vectors;
        add_row("addu_imm", addu, 32'h00001000, 32'h0, 16'h0234, 5'd1, 32'h00001234, exc_none);
        add_row("add_neg_imm", add, 32'h00000100, 32'h0, 16'hfff0, 5'd2, 32'h000000f0, exc_none);
        add_row("add_ov", add, 32'h7fffffff, 32'h0, 16'h0001, 5'd3, 32'h0, exc_ov);
        add_row("addu_wrap", addu, 32'h7fffffff, 32'h0, 16'h0001, 5'd4, 32'h80000000, exc_none);
        add_row("sub_imm", sub, 32'h00000050, 32'h0, 16'h0020, 5'd5, 32'h00000030, exc_none);
        add_row("sub_ov", sub, 32'h80000000, 32'h0, 16'h0001, 5'd6, 32'h0, exc_ov);
        add_row("and_zext", and_op, 32'hf0f01234, 32'h0, 16'hff0f, 5'd7, 32'h00001204, exc_none);
        add_row("or_zext", or_op, 32'h12000000, 32'h0, 16'h8001, 5'd8, 32'h12008001, exc_none);
        add_row("xor_zext", xor_op, 32'h0000ffff, 32'h0, 16'h0f0f, 5'd9, 32'h0000f0f0, exc_none);
        add_row("slt_true", slt, 32'hfffffffe, 32'h0, 16'h0001, 5'd10, 32'h1, exc_none);
        add_row("slt_false", slt, 32'h00000005, 32'h0, 16'hfffb, 5'd11, 32'h0, exc_none);
        add_row("sltu_true", sltu, 32'h00000001, 32'h0, 16'hffff, 5'd12, 32'h1, exc_none);
        add_row("sltu_false", sltu, 32'hfffffffe, 32'h0, 16'h0001, 5'd13, 32'h0, exc_none);
        add_row("sll_4", sll, 32'h0, 32'h000000f1, 16'h0100, 5'd14, 32'h00000f10, exc_none);
        add_row("srl_31", srl, 32'h0, 32'h80000000, 16'h07c0, 5'd15, 32'h00000001, exc_none);
        add_row("sra_4", sra, 32'h0, 32'h80000000, 16'h0100, 5'd16, 32'hf8000000, exc_none);
        add_row("lui", lui, 32'h0, 32'h0, 16'hbeef, 5'd17, 32'hbeef0000, exc_none);
        // word 0x20 and word 0x10 come from the host
        add_row("lw_preload", lw, 32'h00000080, 32'h0, 16'h0, 5'd18, 32'hcafef00d, exc_none);
        add_row("sw_word", sw, 32'h00000100, 32'h89abcdef, 16'h0, 5'd19, 32'h100, exc_none);
        add_row("lw_word", lw, 32'h00000100, 32'h0, 16'h0, 5'd20, 32'h89abcdef, exc_none);
        add_row("sw_clear", sw, 32'h00000104, 32'h0, 16'h0, 5'd21, 32'h104, exc_none);
        add_row("sh_upper", sh, 32'h00000104, 32'h1234beef, 16'h2, 5'd22, 32'h106, exc_none);
        add_row("lw_half", lw, 32'h00000104, 32'h0, 16'h0, 5'd23, 32'hbeef0000, exc_none);
        add_row("lb_neg", lb, 32'h00000104, 32'h0, 16'h3, 5'd24, 32'hffffffbe, exc_none);
        add_row("lbu_half", lbu, 32'h00000104, 32'h0, 16'h2, 5'd25, 32'h000000ef, exc_none);
        add_row("sb_byte1", sb, 32'h00000100, 32'h0000005a, 16'h1, 5'd26, 32'h101, exc_none);
        add_row("lb_pos", lb, 32'h00000100, 32'h0, 16'h1, 5'd27, 32'h0000005a, exc_none);
        add_row("lbu_top", lbu, 32'h00000100, 32'h0, 16'h3, 5'd28, 32'h00000089, exc_none);
        add_row("lb_top", lb, 32'h00000100, 32'h0, 16'h3, 5'd29, 32'hffffff89, exc_none);
        add_row("lw_merged", lw, 32'h00000100, 32'h0, 16'h0, 5'd30, 32'h89ab5aef, exc_none);
        add_row("sw_misalign", sw, 32'h00000040, 32'hdeadbeef, 16'h2, 5'd31, 32'h0, exc_ades);
        add_row("lw_unchanged", lw, 32'h00000040, 32'h0, 16'h0, 5'd1, 32'h11112222, exc_none);
        add_row("lw_misalign", lw, 32'h00000100, 32'h0, 16'h2, 5'd2, 32'h0, exc_adel);
        add_row("mult_pos", mult, 32'h12345678, 32'h100, 16'h0, 5'd3, 32'h12345678, exc_none);
        add_row("mfhi_pos", mfhi, 32'h0, 32'h0, 16'h0, 5'd4, 32'h00000012, exc_none);
        add_row("mflo_pos", mflo, 32'h0, 32'h0, 16'h0, 5'd5, 32'h34567800, exc_none);
        add_row("mult_neg", mult, 32'hfffffffd, 32'h5, 16'h0, 5'd6, 32'hfffffffd, exc_none);
        add_row("mfhi_neg", mfhi, 32'h0, 32'h0, 16'h0, 5'd7, 32'hffffffff, exc_none);
        add_row("mflo_neg", mflo, 32'h0, 32'h0, 16'h0, 5'd8, 32'hfffffff1, exc_none);
        add_row("div_signed", div, 32'hffffff9c, 32'h7, 16'h0, 5'd9, 32'hffffff9c, exc_none);
        add_row("mfhi_div", mfhi, 32'h0, 32'h0, 16'h0, 5'd10, 32'hfffffffe, exc_none);
        add_row("mflo_div", mflo, 32'h0, 32'h0, 16'h0, 5'd11, 32'hfffffff2, exc_none);
        add_row("divu", divu, 32'h000003e8, 32'h7, 16'h0, 5'd12, 32'h000003e8, exc_none);
        add_row("mfhi_divu", mfhi, 32'h0, 32'h0, 16'h0, 5'd13, 32'h00000006, exc_none);
        add_row("mflo_divu", mflo, 32'h0, 32'h0, 16'h0, 5'd14, 32'h0000008e, exc_none);
        add_row("divu_zero", divu, 32'h00001234, 32'h0, 16'h0, 5'd15, 32'h00001234, exc_none);
        add_row("mfhi_zero", mfhi, 32'h0, 32'h0, 16'h0, 5'd16, 32'h00001234, exc_none);
        add_row("mflo_zero", mflo, 32'h0, 32'h0, 16'h0, 5'd17, 32'hffffffff, exc_none);
    endtask

// ==== tb_exec_core.sv ====
`default_nettype none

module tb_exec_core import mycpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int max_rows       = 64;
    localparam int accept_timeout = 200;   // cycles, covers a divide under stalls
    localparam int result_timeout = 200;
    localparam int grant_timeout  = 20;

    logic      clk;
    logic      reset;
    logic      flush;
    logic      in_valid;
    logic      in_allowin;
    op_t       in_op;
    word_t     in_rs;
    word_t     in_rt;
    imm_t      in_imm;
    reg_id_t   in_dest;
    logic      wb_allowin;
    logic      out_valid;
    reg_id_t   out_dest;
    word_t     out_result;
    exc_t      out_exc;
    logic      host_req;
    logic      host_we;
    ram_addr_t host_addr;
    word_t     host_wdata;
    logic      host_gnt;
    word_t     host_rdata;

    // vector table
    string   row_name   [max_rows];
    op_t     row_op     [max_rows];
    word_t   row_rs     [max_rows];
    word_t   row_rt     [max_rows];
    imm_t    row_imm    [max_rows];
    reg_id_t row_dest   [max_rows];
    word_t   row_result [max_rows];
    exc_t    row_exc    [max_rows];
    int      n_rows;

    int          errors;
    int          checks;
    int          timeouts;
    logic [31:0] lfsr;

    exec_core_top #(
        .ram_words (256)
    ) dut_i (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_allowin (in_allowin),
        .in_op      (in_op),
        .in_rs      (in_rs),
        .in_rt      (in_rt),
        .in_imm     (in_imm),
        .in_dest    (in_dest),
        .wb_allowin (wb_allowin),
        .out_valid  (out_valid),
        .out_dest   (out_dest),
        .out_result (out_result),
        .out_exc    (out_exc),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_gnt   (host_gnt),
        .host_rdata (host_rdata)
    );

    always #20 clk = ~clk;

    function automatic void add_row(input string name, input op_t op, input word_t rs,
                                    input word_t rt, input imm_t imm, input reg_id_t dest,
                                    input word_t result, input exc_t exc);
        row_name[n_rows]   = name;
        row_op[n_rows]     = op;
        row_rs[n_rows]     = rs;
        row_rt[n_rows]     = rt;
        row_imm[n_rows]    = imm;
        row_dest[n_rows]   = dest;
        row_result[n_rows] = result;
        row_exc[n_rows]    = exc;
        n_rows++;
    endfunction

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic take_bit();
        take_bit = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    endfunction

    task finish_run;
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task abort_run(input string why);
        $display("%s", why);
        timeouts++;
        finish_run();
    endtask

    task send_instr(input op_t op, input word_t rs, input word_t rt, input imm_t imm,
                    input reg_id_t dest);
        int waited;
        @(negedge clk);
        in_valid = 1'b1;
        in_op    = op;
        in_rs    = rs;
        in_rt    = rt;
        in_imm   = imm;
        in_dest  = dest;
        #10;   // handshake settled, taken at the next rising edge
        waited = 0;
        while (!in_allowin && waited < accept_timeout) begin
            @(negedge clk);
            #10;
            waited++;
        end
        if (!in_allowin) abort_run("execute stage did not accept an instruction in time");
    endtask

    task host_access(input logic we, input ram_addr_t addr, input word_t wdata,
                     output word_t rdata);
        int waited;
        @(negedge clk);
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = wdata;
        #10;
        waited = 0;
        while (!host_gnt && waited < grant_timeout) begin
            @(negedge clk);
            #10;
            waited++;
        end
        if (!host_gnt) abort_run("host port was never granted");
        @(negedge clk);
        host_req = 1'b0;
        host_we  = 1'b0;
        rdata    = host_rdata;   // cycle after the grant
    endtask

    task check_host(input string name, input ram_addr_t addr, input word_t expected);
        word_t got;
        host_access(1'b0, addr, '0, got);
        checks++;
        if (got !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, got);
            errors++;
        end
    endtask

    task check_result(input int k);
        checks++;
        if (out_result !== row_result[k]) begin
            $display("ERR %s result expected %h actual %h", row_name[k], row_result[k],
                     out_result);
            errors++;
        end
        if (out_exc !== row_exc[k]) begin
            $display("ERR %s exc expected %0d actual %0d", row_name[k], row_exc[k], out_exc);
            errors++;
        end
        if (out_dest !== row_dest[k]) begin
            $display("ERR %s dest expected %0d actual %0d", row_name[k], row_dest[k],
                     out_dest);
            errors++;
        end
    endtask

    task collect_results;
        int  k;
        int  idle;
        logic a;
        logic b;
        k    = 0;
        idle = 0;
        while (k < n_rows) begin
            @(negedge clk);
            a = take_bit();
            b = take_bit();
            wb_allowin = a | b;
            #10;
            if (out_valid && wb_allowin) begin
                check_result(k);
                k++;
                idle = 0;
            end else if (idle >= result_timeout) begin
                abort_run($sformatf("no result for row %s in time", row_name[k]));
            end else begin
                idle++;
            end
        end
    endtask

    // a div is started and then killed, nothing of it may reach the output
    task flush_divide;
        send_instr(div, 32'h00000064, 32'h00000003, 16'h0000, 5'd7);
        @(negedge clk);
        in_valid = 1'b0;
        repeat (8) @(negedge clk);
        #10;
        checks++;
        if (in_allowin !== 1'b0) begin
            $display("ERR flush_div in_allowin expected 0 actual %b", in_allowin);
            errors++;
        end
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    task drive_rows;
        flush_divide();
        for (int i = 0; i < n_rows; i++) begin
            send_instr(row_op[i], row_rs[i], row_rt[i], row_imm[i], row_dest[i]);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    initial begin
        word_t unused;
        errors     = 0;
        checks     = 0;
        timeouts   = 0;
        n_rows     = 0;
        lfsr       = 32'hba64;
        clk        = 1'b0;
        reset      = 1'b1;
        flush      = 1'b0;
        in_valid   = 1'b0;
        in_op      = addu;
        in_rs      = '0;
        in_rt      = '0;
        in_imm     = '0;
        in_dest    = '0;
        wb_allowin = 1'b1;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        load_vectors();

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #10;
        checks++;
        if (in_allowin !== 1'b1 || out_valid !== 1'b0 || host_gnt !== 1'b0) begin
            $display("handshake outputs wrong after reset");
            errors++;
        end

        host_access(1'b1, 8'h20, 32'hcafef00d, unused);
        host_access(1'b1, 8'h10, 32'h11112222, unused);

        fork
            drive_rows();
            collect_results();
        join

        @(negedge clk);
        wb_allowin = 1'b1;
        repeat (10) begin
            @(negedge clk);
            #10;
            if (out_valid) begin
                $display("extra result seen after the last row");
                errors++;
            end
        end

        check_host("host_rd_cpu_word", 8'h40, 32'h89ab5aef);
        check_host("host_rd_half_word", 8'h41, 32'hbeef0000);
        check_host("host_rd_ades_word", 8'h10, 32'h11112222);
        finish_run();
    end

    `include "tb_vectors.svh"

endmodule

`default_nettype wire

// ==== exec_core_top.sv ====
`default_nettype none

module exec_core_top import mycpu_pkg::*; #(
    parameter int ram_words = 256
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  logic      in_valid,
    output logic      in_allowin,
    input  op_t       in_op,
    input  word_t     in_rs,
    input  word_t     in_rt,
    input  imm_t      in_imm,
    input  reg_id_t   in_dest,
    input  logic      wb_allowin,
    output logic      out_valid,
    output reg_id_t   out_dest,
    output word_t     out_result,
    output exc_t      out_exc,
    input  logic      host_req,
    input  logic      host_we,
    input  ram_addr_t host_addr,
    input  word_t     host_wdata,
    output logic      host_gnt,
    output word_t     host_rdata
);

    exe_req_t  req;
    es_to_ms_t es_to_ms;
    logic      es_to_ms_valid;
    logic      ms_allowin;

    ram_if cpu_bus ();
    ram_if ram_bus ();

    assign req = '{op: in_op, rs_value: in_rs, rt_value: in_rt, imm: in_imm, dest: in_dest};

    exe_stage u_exe_stage (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .in_valid       (in_valid),
        .in_allowin     (in_allowin),
        .req            (req),
        .ms_allowin     (ms_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms       (es_to_ms),
        .ram            (cpu_bus.master)
    );

    mem_stage u_mem_stage (
        .clk            (clk),
        .reset          (reset),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms       (es_to_ms),
        .ms_allowin     (ms_allowin),
        .ram_rdata      (cpu_bus.rdata),
        .wb_allowin     (wb_allowin),
        .out_valid      (out_valid),
        .out_dest       (out_dest),
        .out_result     (out_result),
        .out_exc        (out_exc)
    );

    ram_arbiter u_ram_arbiter (
        .clk        (clk),
        .reset      (reset),
        .cpu        (cpu_bus.slave),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_gnt   (host_gnt),
        .host_rdata (host_rdata),
        .ram        (ram_bus.master)
    );

    data_ram #(
        .ram_words (ram_words)
    ) u_data_ram (
        .clk (clk),
        .bus (ram_bus.slave)
    );

endmodule

`default_nettype wire

// ==== ram_arbiter.sv ====
`default_nettype none

module ram_arbiter import mycpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    ram_if.slave      cpu,
    input  logic      host_req,
    input  logic      host_we,
    input  ram_addr_t host_addr,
    input  word_t     host_wdata,
    output logic      host_gnt,
    output word_t     host_rdata,
    ram_if.master     ram
);

    logic host_rd_q;   // last cycle was a host read

    assign host_gnt = host_req && !cpu.en;   // cpu always wins

    assign ram.en    = cpu.en || host_gnt;
    assign ram.wen   = cpu.en ? cpu.wen : {4{host_gnt && host_we}};
    assign ram.addr  = cpu.en ? cpu.addr : host_addr;
    assign ram.wdata = cpu.en ? cpu.wdata : host_wdata;

    assign cpu.rdata  = ram.rdata;
    assign host_rdata = host_rd_q ? ram.rdata : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            host_rd_q <= 1'b0;
        end else begin
            host_rd_q <= host_gnt && !host_we;
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(host_gnt && cpu.en));

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
`default_nettype none

module mem_stage import mycpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      es_to_ms_valid,
    input  es_to_ms_t es_to_ms,
    output logic      ms_allowin,
    input  word_t     ram_rdata,
    input  logic      wb_allowin,
    output logic      out_valid,
    output reg_id_t   out_dest,
    output word_t     out_result,
    output exc_t      out_exc
);

    logic      ms_valid;
    logic      ms_first;   // rdata is on the bus this cycle
    logic      out_go;
    es_to_ms_t ms_r;
    word_t     rdata_q, load_word, ms_result;
    logic [7:0] ld_byte;

    assign out_go     = !out_valid || wb_allowin;
    assign ms_allowin = !ms_valid || out_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
            ms_first <= 1'b0;
        end else begin
            if (ms_allowin) ms_valid <= es_to_ms_valid;
            ms_first <= es_to_ms_valid && ms_allowin;
        end
        if (es_to_ms_valid && ms_allowin) ms_r <= es_to_ms;
        if (ms_first) rdata_q <= ram_rdata;   // survives a stall
    end

    assign load_word = ms_first ? ram_rdata : rdata_q;
    assign ld_byte   = load_word[{ms_r.offset, 3'b000} +: 8];

    always_comb begin
        if (ms_r.exc != exc_none) begin
            ms_result = '0;
        end else if (!ms_r.is_load) begin
            ms_result = ms_r.result;
        end else begin
            case (ms_r.op)
                lb:      ms_result = {{24{ld_byte[7]}}, ld_byte};
                lbu:     ms_result = {24'b0, ld_byte};
                default: ms_result = load_word;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (out_go) begin
            out_valid <= ms_valid;
        end
        if (ms_valid && out_go) begin
            out_dest   <= ms_r.dest;
            out_result <= ms_result;
            out_exc    <= ms_r.exc;
        end
    end

    // upstream holds its instruction while stalled
    assert property (@(posedge clk) disable iff (reset)
        es_to_ms_valid && !ms_allowin |=> $stable(es_to_ms));

endmodule

`default_nettype wire

// ==== exe_stage.sv ====
`default_nettype none

module exe_stage import mycpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  logic      in_valid,
    output logic      in_allowin,
    input  exe_req_t  req,
    input  logic      ms_allowin,
    output logic      es_to_ms_valid,
    output es_to_ms_t es_to_ms,
    ram_if.master     ram
);

    typedef enum logic [1:0] {div_idle, div_run, div_fin} div_state_t;

    logic        es_valid;
    exe_req_t    es_r;
    div_state_t  div_state;
    logic        is_div, is_load, is_store;
    logic        es_ready_go, es_fire, mem_go;
    logic        div_start, div_done;
    logic        alu_ov, ades, adel, ov;
    alu_op_t     alu_op;
    word_t       src1, src2, alu_result;
    word_t       hi, lo, quotient, remainder, st_wdata;
    byte_en_t    st_wen;
    exc_t        exc;
    logic [63:0] product;

    assign is_div   = es_r.op inside {div, divu};
    assign is_load  = es_r.op inside {lw, lb, lbu};
    assign is_store = es_r.op inside {sw, sh, sb};

    assign es_ready_go    = !is_div || div_done || (div_state == div_fin);
    assign in_allowin     = !flush && (!es_valid || (es_ready_go && ms_allowin));
    assign es_to_ms_valid = es_valid && es_ready_go && !flush;
    assign es_fire        = es_to_ms_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (flush) begin
            es_valid <= 1'b0;
        end else if (in_allowin) begin
            es_valid <= in_valid;
        end
        if (in_valid && in_allowin) begin
            es_r <= req;
        end
    end

    assign div_start = es_valid && is_div && (div_state == div_idle) && !flush;

    always_ff @(posedge clk) begin
        if (reset || flush || es_fire) begin
            div_state <= div_idle;
        end else if (div_start) begin
            div_state <= div_run;
        end else if (div_done) begin
            div_state <= div_fin;   // hold until mem stage takes it
        end
    end

    always_comb begin
        case (es_r.op)
            sll, srl, sra: src1 = {27'b0, es_r.imm[10:6]};
            mfhi:          src1 = hi;
            mflo:          src1 = lo;
            default:       src1 = es_r.rs_value;
        endcase
        case (es_r.op)
            addu, add, sub, slt, sltu, lw, lb, lbu, sw, sh, sb:
                src2 = {{16{es_r.imm[15]}}, es_r.imm};
            and_op, or_op, xor_op, lui:
                src2 = {16'b0, es_r.imm};
            default:
                src2 = es_r.rt_value;
        endcase
        case (es_r.op)
            addu, add, lw, lb, lbu, sw, sh, sb: alu_op = alu_add;
            sub:     alu_op = alu_sub;
            slt:     alu_op = alu_slt;
            sltu:    alu_op = alu_sltu;
            and_op:  alu_op = alu_and;
            or_op:   alu_op = alu_or;
            xor_op:  alu_op = alu_xor;
            sll:     alu_op = alu_sll;
            srl:     alu_op = alu_srl;
            sra:     alu_op = alu_sra;
            lui:     alu_op = alu_lui;
            default: alu_op = alu_pass;  // hi/lo moves, mult/div pass rs
        endcase
    end

    alu u_alu (
        .alu_op (alu_op),
        .src1   (src1),
        .src2   (src2),
        .result (alu_result),
        .ov     (alu_ov)
    );

    divider u_divider (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .start     (div_start),
        .is_signed (es_r.op == div),
        .dividend  (es_r.rs_value),
        .divisor   (es_r.rt_value),
        .quotient  (quotient),
        .remainder (remainder),
        .done      (div_done)
    );

    store_align u_store_align (
        .op       (es_r.op),
        .addr_lo  (alu_result[1:0]),
        .rt_value (es_r.rt_value),
        .wen      (st_wen),
        .wdata    (st_wdata),
        .ades     (ades)
    );

    assign product = $signed(es_r.rs_value) * $signed(es_r.rt_value);

    always_ff @(posedge clk) begin
        if (es_fire && es_r.op == mult) begin
            hi <= product[63:32];
            lo <= product[31:0];
        end else if (div_done && !flush) begin
            hi <= remainder;
            lo <= quotient;
        end
    end

    assign ov   = (es_r.op == add || es_r.op == sub) && alu_ov;
    assign adel = (es_r.op == lw) && (alu_result[1:0] != 2'b00);
    assign exc  = ov ? exc_ov : adel ? exc_adel : ades ? exc_ades : exc_none;

    // access only on the cycle the instruction moves on
    assign mem_go    = es_fire && (is_load || is_store) && (exc == exc_none);
    assign ram.en    = mem_go;
    assign ram.wen   = st_wen & {4{mem_go}};
    assign ram.addr  = alu_result[9:2];
    assign ram.wdata = st_wdata;

    assign es_to_ms = '{op: es_r.op, dest: es_r.dest, result: alu_result, exc: exc,
                        offset: alu_result[1:0], is_load: is_load && (exc == exc_none)};

    assert property (@(posedge clk) disable iff (reset) !es_valid |-> ram.wen == '0);

endmodule

`default_nettype wire

// ==== data_ram.sv ====
`default_nettype none

interface ram_if import mycpu_pkg::*; ();
    logic      en;
    byte_en_t  wen;
    ram_addr_t addr;
    word_t     wdata;
    word_t     rdata;   // one cycle after en

    modport master (output en, wen, addr, wdata, input rdata);
    modport slave  (input en, wen, addr, wdata, output rdata);
endinterface

module data_ram import mycpu_pkg::*; #(
    parameter int ram_words = 256
) (
    input  logic clk,
    ram_if.slave bus
);

    word_t mem [ram_words];

    always_ff @(posedge clk) begin
        if (bus.en) begin
            bus.rdata <= mem[bus.addr];
            for (int i = 0; i < 4; i++) begin
                if (bus.wen[i]) mem[bus.addr][8*i +: 8] <= bus.wdata[8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// ==== store_align.sv ====
`default_nettype none

module store_align import mycpu_pkg::*; (
    input  op_t        op,
    input  logic [1:0] addr_lo,
    input  word_t      rt_value,
    output byte_en_t   wen,
    output word_t      wdata,
    output logic       ades
);

    byte_en_t wen_raw;

    always_comb begin
        wdata   = rt_value;
        wen_raw = '0;
        ades    = 1'b0;
        case (op)
            sb: begin
                wdata   = {4{rt_value[7:0]}};
                wen_raw = 4'b0001 << addr_lo;
            end
            sh: begin
                wdata   = {2{rt_value[15:0]}};
                wen_raw = addr_lo[1] ? 4'b1100 : 4'b0011;
                ades    = addr_lo[0];
            end
            sw: begin
                wen_raw = 4'b1111;
                ades    = addr_lo != 2'b00;
            end
            default: ;
        endcase
    end

    assign wen = ades ? '0 : wen_raw;

endmodule

`default_nettype wire

// ==== divider.sv ====
`default_nettype none

module divider import mycpu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  flush,
    input  logic  start,
    input  logic  is_signed,
    input  word_t dividend,
    input  word_t divisor,
    output word_t quotient,
    output word_t remainder,
    output logic  done
);

    logic        busy;
    logic [5:0]  cnt;
    logic        last;
    logic        q_neg;
    logic        r_neg;
    word_t       rem_q;
    word_t       quo_q;   // dividend shifts out, quotient shifts in
    word_t       dsr_q;
    logic [32:0] shifted;
    logic [33:0] trial;

    assign last    = cnt == 6'(div_cycles - 1);
    assign shifted = {rem_q, quo_q[31]};
    assign trial   = {1'b0, shifted} - {2'b00, dsr_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (flush) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= busy && last;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                busy <= !last;
                cnt  <= cnt + 6'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem_q <= '0;
            quo_q <= (is_signed && dividend[31]) ? -dividend : dividend;
            dsr_q <= (is_signed && divisor[31]) ? -divisor : divisor;
            q_neg <= is_signed && (dividend[31] ^ divisor[31]) && (divisor != '0);
            r_neg <= is_signed && dividend[31];
        end else if (busy && !last) begin
            if (!trial[33]) begin  // restore skipped
                rem_q <= trial[31:0];
                quo_q <= {quo_q[30:0], 1'b1};
            end else begin
                rem_q <= shifted[31:0];
                quo_q <= {quo_q[30:0], 1'b0};
            end
        end
        if (busy && last) begin
            quotient  <= q_neg ? -quo_q : quo_q;
            remainder <= r_neg ? -rem_q : rem_q;
        end
    end

    assert property (@(posedge clk) disable iff (reset) busy |-> !start);

endmodule

`default_nettype wire

// ==== alu.sv ====
`default_nettype none

module alu import mycpu_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   src1,
    input  word_t   src2,
    output word_t   result,
    output logic    ov
);

    word_t sum;
    word_t diff;

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    always_comb begin
        case (alu_op)
            alu_add:  result = sum;
            alu_sub:  result = diff;
            alu_slt:  result = {31'b0, $signed(src1) < $signed(src2)};
            alu_sltu: result = {31'b0, src1 < src2};
            alu_and:  result = src1 & src2;
            alu_or:   result = src1 | src2;
            alu_xor:  result = src1 ^ src2;
            alu_sll:  result = src2 << src1[4:0];
            alu_srl:  result = src2 >> src1[4:0];
            alu_sra:  result = $signed(src2) >>> src1[4:0];
            alu_lui:  result = {src2[15:0], 16'b0};
            default:  result = src1;   // pass, used for mfhi/mflo
        endcase
    end

    // signed overflow, operands alike in sign but result differs
    always_comb begin
        case (alu_op)
            alu_add: ov = (src1[31] == src2[31]) && (sum[31] != src1[31]);
            alu_sub: ov = (src1[31] != src2[31]) && (diff[31] != src1[31]);
            default: ov = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== mycpu_pkg.sv ====
`default_nettype none

package mycpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_id_t;
    typedef logic [15:0] imm_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [7:0]  ram_addr_t;   // word address, byte address bits 9:2

    typedef enum logic [4:0] {
        addu, add, sub, and_op, or_op, xor_op, slt, sltu, sll, srl, sra, lui,
        lw, lb, lbu, sw, sh, sb,
        mult, div, divu, mfhi, mflo
    } op_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui, alu_pass
    } alu_op_t;

    typedef enum logic [1:0] {exc_none, exc_ov, exc_adel, exc_ades} exc_t;

    typedef struct packed {
        op_t     op;
        word_t   rs_value;
        word_t   rt_value;
        imm_t    imm;
        reg_id_t dest;
    } exe_req_t;

    typedef struct packed {
        op_t        op;
        reg_id_t    dest;
        word_t      result;
        exc_t       exc;
        logic [1:0] offset;    // byte within the word
        logic       is_load;   // a read was issued to the RAM
    } es_to_ms_t;

    localparam int div_cycles = 33;

endpackage

`default_nettype wire
